//--- tests/dcache_tests.txt
# op size addr value id expect, all hex, size 0 byte 1 half 2 word
# L load S store N load without waiting D collect loads W idle cycles given by value
L 2 00000100 00000000 01 a5a50100
L 2 00000100 00000000 02 a5a50100
S 2 00000104 12345678 03 00000000
S 1 00000106 0000beef 04 00000000
S 0 00000101 00000077 05 00000000
L 0 00000103 00000000 06 000000a5
L 1 00000102 00000000 07 0000a5a5
L 1 00000100 00000000 08 00007700
L 2 00000104 00000000 09 beef5678
L 0 00000107 00000000 0a 000000be
L 2 00000100 00000000 0b a5a57700
L 1 00000105 00000000 0c 0000ef56
W 0 00000000 00000003 00 00000000
S 2 00000208 cafef00d 0d 00000000
L 2 00000208 00000000 0e cafef00d
L 2 0000020c 00000000 0f a5a5020c
L 0 0000020b 00000000 1f 000000ca
L 2 00000418 00000000 10 a5a50418
L 2 00000498 00000000 11 a5a50498
S 2 0000041c 0badcafe 12 00000000
S 0 00000498 0000005a 13 00000000
L 2 00000518 00000000 14 a5a50518
L 2 0000041c 00000000 15 0badcafe
L 2 00000418 00000000 16 a5a50418
L 0 00000498 00000000 17 0000005a
L 2 0000049c 00000000 18 a5a5049c
W 0 00000000 00000002 00 00000000
N 2 00000840 00000000 20 a5a50840
N 2 00000848 00000000 21 a5a50848
N 2 00000850 00000000 22 a5a50850
N 1 0000085a 00000000 23 0000a5a5
D 0 00000000 00000000 00 00000000
L 2 00000840 00000000 24 a5a50840
L 1 0000085a 00000000 25 0000a5a5

//--- sources.f
src/dcache_pkg.sv
src/cache_array.sv
src/mshr_file.sv
src/mem_port.sv
src/dcache_top.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP = dcache_tb
FILELIST = sources.f
BUILD = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

//--- tests/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int MSHRS = 4;
    localparam int WAIT_LIMIT = 64;

    logic       clock = 1'b0;
    logic       reset;
    lsq_req_t   lsq_req;
    mem_resp_t  mem_resp;
    lsq_resp_t  hit_resp;
    lsq_resp_t  replay_resp;
    mem_req_t   mem_req;
    logic       busy;

    mem_tag_t   grant_tag;
    logic       advance_grant;
    mem_tag_t   done_tag;
    line_t      done_data;

    // memory model state
    line_t      shadow [addr_t];
    mem_tag_t   pend_tag [$];
    addr_t      pend_addr [$];
    int         pend_left [$];
    logic [7:0] lfsr;
    int         in_use;

    // expected residency, least recently used replacement
    tag_t       model_tag [SET_COUNT][WAYS];
    logic       model_valid [SET_COUNT][WAYS];
    logic       model_mru [SET_COUNT];

    logic       seen [256];
    word_t      seen_value [256];
    addr_t      seen_addr [256];
    logic       seen_store [256];
    req_id_t    nb_id [$];
    addr_t      nb_addr [$];
    word_t      nb_expect [$];

    int         value_errors;
    int         other_errors;

    dcache_top #(
        .MSHR_COUNT (MSHRS)
    ) dut (
        .clock       (clock),
        .reset       (reset),
        .lsq_req     (lsq_req),
        .mem_resp    (mem_resp),
        .hit_resp    (hit_resp),
        .replay_resp (replay_resp),
        .mem_req     (mem_req),
        .busy        (busy)
    );

    // tag is granted in the same cycle as the load command
    assign mem_resp = '{response: (mem_req.command == BUS_LOAD) ? grant_tag : mem_tag_t'(0),
                        tag: done_tag, data: done_data};

    always #4 clock = ~clock;

    function automatic word_t pattern_word(addr_t a);
        return a ^ 32'ha5a5_0000;
    endfunction

    function automatic line_t read_line(addr_t a);
        addr_t base;
        base = {a[31:3], 3'b000};
        if (shadow.exists(base)) begin
            return shadow[base];
        end
        return {pattern_word(base + 32'd4), pattern_word(base)};
    endfunction

    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_delay(output int delay);
        logic [1:0] bits;
        bits = 2'b00;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[0], lfsr[0]};
        end
        delay = 1 + int'(bits);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got == expected) else begin
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond) else begin
            $display("ERROR %0t ns %s", $time, what);
            other_errors++;
        end
    endtask

    // predicts a hit, a miss installs over the older way
    task automatic track_line(input addr_t addr, output logic resident);
        index_t set_index;
        tag_t   line_tag;
        int     way;
        set_index = addr[6:3];
        line_tag = addr[31:7];
        way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set_index][w] && model_tag[set_index][w] == line_tag) begin
                way = w;
            end
        end
        resident = (way >= 0);
        if (!resident) begin
            way = model_mru[set_index] ? 0 : 1;
            model_valid[set_index][way] = 1'b1;
            model_tag[set_index][way] = line_tag;
        end
        model_mru[set_index] = (way == 1);
    endtask

    // one completion per cycle, oldest due first
    task automatic present_completion();
        int pick;
        pick = -1;
        if (advance_grant) begin
            grant_tag = (grant_tag == 4'd15) ? 4'd1 : grant_tag + 4'd1;
            advance_grant = 1'b0;
        end
        done_tag = '0;
        done_data = '0;
        foreach (pend_left[i]) begin
            pend_left[i]--;
            if (pend_left[i] <= 0 && pick < 0) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            done_tag = pend_tag[pick];
            done_data = read_line(pend_addr[pick]);
            pend_tag.delete(pick);
            pend_addr.delete(pick);
            pend_left.delete(pick);
        end
    endtask

    always begin
        int delay;
        @(negedge clock);
        present_completion();
        #2;
        if (reset) begin
            in_use = 0;
        end else begin
            if (in_use == MSHRS) begin
                check_true("busy is low while every miss entry is in use", busy);
            end
            if (mem_req.command == BUS_LOAD) begin
                draw_delay(delay);
                pend_tag.push_back(grant_tag);
                pend_addr.push_back(mem_req.addr);
                pend_left.push_back(delay);
                advance_grant = 1'b1;
                in_use++;
            end else if (mem_req.command == BUS_STORE) begin
                shadow[mem_req.addr] = mem_req.data;
            end
            if (replay_resp.valid) begin
                seen[replay_resp.id] = 1'b1;
                seen_value[replay_resp.id] = replay_resp.value;
                seen_addr[replay_resp.id] = replay_resp.addr;
                seen_store[replay_resp.id] = replay_resp.store;
                in_use--;
            end
        end
    end

    // called at a falling edge, returns at a falling edge
    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            lsq_req = '0;
            @(negedge clock);
            n++;
        end
        check_true("busy never dropped", !busy);
    endtask

    task automatic wait_replay(input req_id_t id, input logic store, input addr_t addr,
                               input word_t expected);
        int n;
        n = 0;
        while (!seen[id] && n < WAIT_LIMIT) begin
            @(negedge clock);
            #3;
            n++;
        end
        check_true($sformatf("no replay arrived for id %h", id), seen[id]);
        if (seen[id]) begin
            check_value("replay_resp.value", seen_value[id], expected);
            check_value("replay_resp.addr", seen_addr[id], addr);
            check_value("replay_resp.store", 32'(seen_store[id]), 32'(store));
        end
        @(negedge clock);
    endtask

    task automatic issue_request(input logic store, input mem_size_t size, input addr_t addr,
                                 input word_t value, input req_id_t id, input word_t expected,
                                 input logic blocking);
        logic  resident;
        word_t result;
        result = store ? word_t'(0) : expected;
        wait_not_busy();
        track_line(addr, resident);
        seen[id] = 1'b0;
        lsq_req = '{valid: 1'b1, store: store, size: size, addr: addr, value: value, id: id};
        #2;
        check_value("hit_resp.valid", 32'(hit_resp.valid), 32'(resident));
        if (resident) begin
            check_value("hit_resp.value", hit_resp.value, result);
            check_value("hit_resp.id", 32'(hit_resp.id), 32'(id));
            check_value("hit_resp.addr", hit_resp.addr, addr);
            check_value("hit_resp.store", 32'(hit_resp.store), 32'(store));
        end else begin
            check_value("mem_req.command", 32'(mem_req.command), 32'(BUS_LOAD));
            check_value("mem_req.addr", mem_req.addr, {addr[31:3], 3'b000});
        end
        @(negedge clock);
        lsq_req = '0;
        if (!resident && blocking) begin
            wait_replay(id, store, addr, result);
        end else if (!resident) begin
            nb_id.push_back(id);
            nb_addr.push_back(addr);
            nb_expect.push_back(result);
        end
    endtask

    task automatic drain_loads();
        foreach (nb_id[i]) begin
            wait_replay(nb_id[i], 1'b0, nb_addr[i], nb_expect[i]);
        end
        nb_id.delete();
        nb_addr.delete();
        nb_expect.delete();
    endtask

    initial begin
        int           fd;
        int           got;
        logic [1023:0] text;
        logic [7:0]   op;
        logic [31:0]  f_size;
        logic [31:0]  f_addr;
        logic [31:0]  f_value;
        logic [31:0]  f_id;
        logic [31:0]  f_expect;
        reset = 1'b1;
        lsq_req = '0;
        done_tag = '0;
        done_data = '0;
        grant_tag = 4'd1;
        advance_grant = 1'b0;
        lfsr = 8'd34;
        in_use = 0;
        value_errors = 0;
        other_errors = 0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        foreach (model_mru[s]) begin
            model_mru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #2;
        check_true("hit_resp valid after reset", !hit_resp.valid);
        check_true("replay_resp valid after reset", !replay_resp.valid);
        check_true("busy high after reset", !busy);
        check_value("mem_req.command", 32'(mem_req.command), 32'(BUS_NONE));
        @(negedge clock);
        fd = $fopen("tests/dcache_tests.txt", "r");
        check_true("cannot open tests/dcache_tests.txt", fd != 0);
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = '0;
                got = $fgets(text, fd);
                if (got > 0) begin
                    got = $sscanf(text, "%s %h %h %h %h %h", op, f_size, f_addr, f_value,
                                  f_id, f_expect);
                    if (got == 6) begin
                        case (op)
                            "L": issue_request(1'b0, mem_size_t'(f_size[1:0]), f_addr, f_value,
                                               f_id[7:0], f_expect, 1'b1);
                            "S": issue_request(1'b1, mem_size_t'(f_size[1:0]), f_addr, f_value,
                                               f_id[7:0], f_expect, 1'b1);
                            "N": issue_request(1'b0, mem_size_t'(f_size[1:0]), f_addr, f_value,
                                               f_id[7:0], f_expect, 1'b0);
                            "D": drain_loads();
                            "W": repeat (f_value) @(negedge clock);
                            default: check_true("unknown operation in data file", 1'b0);
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        repeat (4) @(negedge clock);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tests/dcache_sva.sv
module dcache_sva (
    input logic                  clock,
    input logic                  reset,
    input dcache_pkg::lsq_req_t  lsq_req,
    input dcache_pkg::lsq_resp_t hit_resp,
    input dcache_pkg::lsq_resp_t replay_resp,
    input dcache_pkg::mem_req_t  mem_req,
    input logic                  busy,
    input logic                  miss
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    // state is known from the second reset edge on
    assert property (@(posedge clock) (reset && $past(reset)) |->
                     (!hit_resp.valid && !replay_resp.valid))
        else $error("response valid during reset");

    // a line load needs a free entry in the miss table
    assert property (@(posedge clock) disable iff (reset)
                     (mem_req.command == BUS_LOAD) |-> (lsq_req.valid && miss && !busy))
        else $error("line load without a missing request");

    assert property (@(posedge clock) disable iff (reset) busy |-> !lsq_req.valid)
        else $error("request taken while busy");

    assert property (@(posedge clock) disable iff (reset)
                     !(hit_resp.valid && (mem_req.command == BUS_LOAD)))
        else $error("hit and miss in the same cycle");

endmodule

bind dcache_top dcache_sva u_sva (
    .clock       (clock),
    .reset       (reset),
    .lsq_req     (lsq_req),
    .hit_resp    (hit_resp),
    .replay_resp (replay_resp),
    .mem_req     (mem_req),
    .busy        (busy),
    .miss        (miss)
);

//--- src/dcache_top.sv
module dcache_top #(
    parameter int MSHR_COUNT = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  lsq_req,
    input  dcache_pkg::mem_resp_t mem_resp,
    output dcache_pkg::lsq_resp_t hit_resp,
    output dcache_pkg::lsq_resp_t replay_resp,
    output dcache_pkg::mem_req_t  mem_req,
    output logic                  busy
);
    import dcache_pkg::*;

    logic    miss;
    logic    full;
    logic    pending;
    refill_t refill;
    victim_t victim;

    cache_array u_cache_array (
        .clock    (clock),
        .reset    (reset),
        .lsq_req  (lsq_req),
        .refill   (refill),
        .hit_resp (hit_resp),
        .miss     (miss),
        .victim   (victim)
    );

    mshr_file #(
        .MSHR_COUNT (MSHR_COUNT)
    ) u_mshr_file (
        .clock       (clock),
        .reset       (reset),
        .lsq_req     (lsq_req),
        .miss        (miss),
        .mem_resp    (mem_resp),
        .refill      (refill),
        .replay_resp (replay_resp),
        .full        (full)
    );

    mem_port u_mem_port (
        .clock   (clock),
        .reset   (reset),
        .lsq_req (lsq_req),
        .miss    (miss),
        .victim  (victim),
        .mem_req (mem_req),
        .pending (pending)
    );

    // no new misses while the table is full or a writeback waits
    assign busy = full || pending;

endmodule

//--- src/mem_port.sv
module mem_port (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::lsq_req_t lsq_req,
    input  logic                 miss,
    input  dcache_pkg::victim_t  victim,
    output dcache_pkg::mem_req_t mem_req,
    output logic                 pending
);
    import dcache_pkg::*;

    logic  load_now;
    logic  pend_valid_q;
    addr_t pend_addr_q;
    line_t pend_data_q;

    assign load_now = lsq_req.valid && miss;

    // line loads go first, writeback waits for an idle bus
    always_comb begin
        mem_req.command = BUS_NONE;
        mem_req.addr = '0;
        mem_req.data = '0;
        if (load_now) begin
            mem_req.command = BUS_LOAD;
            mem_req.addr = {lsq_req.addr[31:3], offset_t'(0)};
        end else if (pend_valid_q) begin
            mem_req.command = BUS_STORE;
            mem_req.addr = pend_addr_q;
            mem_req.data = pend_data_q;
        end
    end

    // a new victim may replace one leaving on the bus this cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            pend_valid_q <= 1'b0;
        end else if (victim.valid) begin
            pend_valid_q <= 1'b1;
        end else if (!load_now) begin
            pend_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (victim.valid) begin
            pend_addr_q <= victim.addr;
            pend_data_q <= victim.data;
        end
    end

    assign pending = pend_valid_q;

endmodule

//--- src/mshr_file.sv
module mshr_file #(
    parameter int MSHR_COUNT = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  lsq_req,
    input  logic                  miss,
    input  dcache_pkg::mem_resp_t mem_resp,
    output dcache_pkg::refill_t   refill,
    output dcache_pkg::lsq_resp_t replay_resp,
    output logic                  full
);
    import dcache_pkg::*;

    mshr_state_t state_q [MSHR_COUNT];
    lsq_req_t    req_q   [MSHR_COUNT];
    mem_tag_t    mtag_q  [MSHR_COUNT];
    line_t       line_q  [MSHR_COUNT];

    logic                  alloc_en;
    logic [MSHR_COUNT-1:0] free;
    logic [MSHR_COUNT-1:0] match;
    logic [MSHR_COUNT-1:0] ready;
    logic [MSHR_COUNT-1:0] alloc_grant;
    logic [MSHR_COUNT-1:0] fill_grant;
    logic [MSHR_COUNT-1:0] replay_grant;

    // isolate the lowest set bit
    function automatic logic [MSHR_COUNT-1:0] lowest_one(logic [MSHR_COUNT-1:0] bits);
        return bits & (~bits + MSHR_COUNT'(1));
    endfunction

    always_comb begin
        for (int i = 0; i < MSHR_COUNT; i++) begin
            free[i] = (state_q[i] == INVALID);
            ready[i] = (state_q[i] == READY);
            match[i] = (state_q[i] == WAITING) && (mem_resp.tag != '0)
                       && (mtag_q[i] == mem_resp.tag);
        end
    end

    assign alloc_en = lsq_req.valid && miss;
    assign alloc_grant = lowest_one(free) & {MSHR_COUNT{alloc_en}};
    assign fill_grant = lowest_one(match);
    assign replay_grant = lowest_one(ready);
    assign full = ~|free;

    always_comb begin
        refill = '0;
        for (int i = 0; i < MSHR_COUNT; i++) begin
            if (fill_grant[i]) begin
                refill.valid = 1'b1;
                refill.addr = req_q[i].addr;
                refill.size = req_q[i].size;
                refill.store = req_q[i].store;
                refill.value = req_q[i].value;
                refill.data = mem_resp.data;
            end
        end
    end

    // stores replay with zero
    always_comb begin
        replay_resp = '0;
        for (int i = 0; i < MSHR_COUNT; i++) begin
            if (replay_grant[i]) begin
                replay_resp.valid = 1'b1;
                replay_resp.store = req_q[i].store;
                replay_resp.addr = req_q[i].addr;
                replay_resp.id = req_q[i].id;
                if (!req_q[i].store) begin
                    replay_resp.value = extract_load(line_q[i], req_q[i].addr[2:0],
                                                     req_q[i].size);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MSHR_COUNT; i++) begin
                state_q[i] <= INVALID;
            end
        end else begin
            for (int i = 0; i < MSHR_COUNT; i++) begin
                case (state_q[i])
                    INVALID: begin
                        if (alloc_grant[i]) begin
                            state_q[i] <= WAITING;
                        end
                    end
                    WAITING: begin
                        if (fill_grant[i]) begin
                            state_q[i] <= READY;
                        end
                    end
                    READY: begin
                        if (replay_grant[i]) begin
                            state_q[i] <= INVALID;
                        end
                    end
                    default: state_q[i] <= INVALID;
                endcase
            end
        end
    end

    // tag granted by memory in the miss cycle
    always_ff @(posedge clock) begin
        for (int i = 0; i < MSHR_COUNT; i++) begin
            if (alloc_grant[i]) begin
                req_q[i] <= lsq_req;
                mtag_q[i] <= mem_resp.response;
            end
            if (fill_grant[i]) begin
                line_q[i] <= mem_resp.data;
            end
        end
    end

endmodule

//--- src/cache_array.sv
module cache_array (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  lsq_req,
    input  dcache_pkg::refill_t   refill,
    output dcache_pkg::lsq_resp_t hit_resp,
    output logic                  miss,
    output dcache_pkg::victim_t   victim
);
    import dcache_pkg::*;

    logic [SET_COUNT-1:0][WAYS-1:0] valid_q;
    logic [SET_COUNT-1:0]           mru_q;
    tag_t                           tag_q  [SET_COUNT][WAYS];
    line_t                          line_q [SET_COUNT][WAYS];

    tag_t            req_tag;
    index_t          req_index;
    offset_t         req_offset;
    logic [WAYS-1:0] req_match;
    logic            hit;
    logic            hit_way;
    line_t           hit_line;
    line_t           store_line;

    tag_t            fill_tag;
    index_t          fill_index;
    offset_t         fill_offset;
    logic [WAYS-1:0] fill_match;
    logic            fill_present;
    logic            fill_way;
    logic            store_hit_here;
    line_t           fill_base;
    line_t           fill_src;
    line_t           fill_line;

    logic            victim_valid_q;
    addr_t           victim_addr_q;
    line_t           victim_data_q;

    assign {req_tag, req_index, req_offset} = lsq_req.addr;
    assign {fill_tag, fill_index, fill_offset} = refill.addr;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            req_match[w] = valid_q[req_index][w] && (tag_q[req_index][w] == req_tag);
            fill_match[w] = valid_q[fill_index][w] && (tag_q[fill_index][w] == fill_tag);
        end
    end

    assign hit = lsq_req.valid && (|req_match);
    assign miss = lsq_req.valid && !(|req_match);
    assign hit_way = req_match[1];
    assign hit_line = line_q[req_index][hit_way];
    assign store_line = merge_store(hit_line, req_offset, lsq_req.size, lsq_req.value);

    always_comb begin
        hit_resp.valid = hit;
        hit_resp.store = lsq_req.store;
        hit_resp.addr = lsq_req.addr;
        hit_resp.value = lsq_req.store ? '0 : extract_load(hit_line, req_offset, lsq_req.size);
        hit_resp.id = lsq_req.id;
    end

    // a second load of a resident line keeps the cached copy
    assign fill_present = |fill_match;
    assign fill_way = fill_present ? fill_match[1] : !mru_q[fill_index];

    // store hit into the way being filled this cycle
    assign store_hit_here = hit && lsq_req.store && (req_index == fill_index)
                            && (hit_way == fill_way);
    assign fill_base = store_hit_here ? store_line : line_q[fill_index][fill_way];
    assign fill_src = fill_present ? fill_base : refill.data;

    always_comb begin
        if (refill.store) begin
            fill_line = merge_store(fill_src, fill_offset, refill.size, refill.value);
        end else begin
            fill_line = fill_src;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            mru_q <= '0;
            victim_valid_q <= 1'b0;
        end else begin
            victim_valid_q <= refill.valid && !fill_present && valid_q[fill_index][fill_way];
            if (hit) begin
                mru_q[req_index] <= hit_way;
            end
            // refill wins the recency bit when both touch a set
            if (refill.valid) begin
                valid_q[fill_index][fill_way] <= 1'b1;
                mru_q[fill_index] <= fill_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit && lsq_req.store) begin
            line_q[req_index][hit_way] <= store_line;
        end
        if (refill.valid) begin
            tag_q[fill_index][fill_way] <= fill_tag;
            line_q[fill_index][fill_way] <= fill_line;
        end
        victim_addr_q <= {tag_q[fill_index][fill_way], fill_index, offset_t'(0)};
        victim_data_q <= fill_base;
    end

    assign victim = '{valid: victim_valid_q, addr: victim_addr_q, data: victim_data_q};

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

    localparam int SET_COUNT = 16;
    localparam int WAYS = 2;

    typedef logic [24:0] tag_t;
    typedef logic [3:0]  index_t;
    typedef logic [2:0]  offset_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] line_t;
    // zero means no transaction
    typedef logic [3:0]  mem_tag_t;
    typedef logic [7:0]  req_id_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;
    typedef enum logic [1:0] {INVALID, WAITING, READY} mshr_state_t;

    typedef struct packed {
        logic      valid;
        logic      store;
        mem_size_t size;
        addr_t     addr;
        word_t     value;
        req_id_t   id;
    } lsq_req_t;

    typedef struct packed {
        logic    valid;
        logic    store;
        addr_t   addr;
        word_t   value;
        req_id_t id;
    } lsq_resp_t;

    typedef struct packed {
        bus_cmd_t command;
        addr_t    addr;
        line_t    data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t response;
        mem_tag_t tag;
        line_t    data;
    } mem_resp_t;

    // miss table to array, one line install per cycle
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_t size;
        logic      store;
        word_t     value;
        line_t     data;
    } refill_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        line_t data;
    } victim_t;

    function automatic line_t merge_store(line_t line, offset_t offset, mem_size_t size,
                                          word_t value);
        line_t mask;
        line_t data;
        case (size)
            BYTE:    mask = line_t'(8'hff);
            HALF:    mask = line_t'(16'hffff);
            default: mask = line_t'(32'hffff_ffff);
        endcase
        mask = mask << {offset, 3'b000};
        data = line_t'(value) << {offset, 3'b000};
        return (line & ~mask) | (data & mask);
    endfunction

    function automatic word_t extract_load(line_t line, offset_t offset, mem_size_t size);
        line_t shifted;
        word_t result;
        shifted = line >> {offset, 3'b000};
        case (size)
            BYTE:    result = word_t'(shifted[7:0]);
            HALF:    result = word_t'(shifted[15:0]);
            default: result = shifted[31:0];
        endcase
        return result;
    endfunction

endpackage
